// File: hdl/posit_pkg.sv
package posit_pkg;

    ////////////////////////////////////////////////////////////
    // posit format
    ////////////////////////////////////////////////////////////

    // one posit word, sign + regime + fraction
    localparam int POSIT_WIDTH = 4;
    // no exponent field in this format
    localparam int POSIT_ES = 0;

    // sign bit set, all other bits clear
    localparam logic [POSIT_WIDTH-1:0] NAR_PATTERN = {1'b1, {(POSIT_WIDTH-1){1'b0}}};

    ////////////////////////////////////////////////////////////
    // decoded operand fields
    ////////////////////////////////////////////////////////////

    // signed scale, -2 .. 2
    localparam int DEC_SCALE_WIDTH = 3;
    // hidden one plus one fraction bit
    localparam int DEC_FRAC_WIDTH = 2;

    ////////////////////////////////////////////////////////////
    // product fields
    ////////////////////////////////////////////////////////////

    // sum of two operand scales, -4 .. 4
    localparam int PROD_SCALE_WIDTH = 4;
    // 2x2 bit significand product
    // weight 1/4 per count, values 4, 6 or 9
    localparam int PROD_FRAC_WIDTH = 4;

endpackage

// File: hdl/quire_pkg.sv
package quire_pkg;

    ////////////////////////////////////////////////////////////
    // quire sizing
    ////////////////////////////////////////////////////////////

    // longest window guaranteed free of overflow is 2**LOG_NB_ACCUM
    localparam int LOG_NB_ACCUM = 10;
    // bits for a single product
    localparam int QUIRE_NQMIN = 11;
    // signed accumulator, lsb weight 2**-QUIRE_FRAC_BITS
    localparam int QUIRE_WIDTH = QUIRE_NQMIN + LOG_NB_ACCUM;

    ////////////////////////////////////////////////////////////
    // binary point offsets
    ////////////////////////////////////////////////////////////

    // fraction bits below the quire binary point
    localparam int QUIRE_FRAC_BITS = 4;
    // product significand binary point, weight 1/4
    localparam int PROD_FRAC_POINT = 2;
    // added to the product scale before the shift
    localparam int SHIFT_BIAS = QUIRE_FRAC_BITS - PROD_FRAC_POINT;
    // aligned addend, largest magnitude 256
    localparam int SHIFTED_WIDTH = 11;

endpackage

// File: hdl/posit_decode.sv
module posit_decode (
    input  logic [posit_pkg::POSIT_WIDTH-1:0]            posit_i,
    output logic                                         sign_o,
    output logic                                         zero_o,
    output logic                                         nar_o,
    output logic signed [posit_pkg::DEC_SCALE_WIDTH-1:0] scale_o,
    output logic [posit_pkg::DEC_FRAC_WIDTH-1:0]         frac_o
);

    // two's complement magnitude of the word
    logic [posit_pkg::POSIT_WIDTH-1:0] mag;
    // everything under the sign bit
    logic [posit_pkg::POSIT_WIDTH-2:0] body;
    // length of the regime run
    logic [1:0]                        run_len;
    logic                              run_end;
    // body with regime and terminator shifted out
    logic [posit_pkg::POSIT_WIDTH-2:0] frac_field;
    logic signed [posit_pkg::DEC_SCALE_WIDTH-1:0] regime_k;

    // special patterns
    assign sign_o = posit_i[posit_pkg::POSIT_WIDTH-1];
    assign zero_o = (posit_i == '0);
    assign nar_o  = (posit_i == posit_pkg::NAR_PATTERN);

    // negative words decode from their two's complement
    assign mag  = sign_o ? (~posit_i + 1'b1) : posit_i;
    assign body = mag[posit_pkg::POSIT_WIDTH-2:0];

    // count identical leading bits of the body
    always_comb begin
        run_len = '0;
        run_end = 1'b0;
        for (int i = posit_pkg::POSIT_WIDTH - 2; i >= 0; i--) begin
            if (!run_end && (body[i] == body[posit_pkg::POSIT_WIDTH-2])) begin
                run_len = run_len + 2'd1;
            end else begin
                run_end = 1'b1;
            end
        end
    end

    // run of ones gives k = run - 1, run of zeros gives k = -run
    assign regime_k = body[posit_pkg::POSIT_WIDTH-2] ?
                      ($signed({1'b0, run_len}) - 3'sd1) :
                      (-$signed({1'b0, run_len}));

    // skip regime bits and the terminator, the next bit is the fraction
    assign frac_field = body << ({1'b0, run_len} + 3'd1);

    // es is zero, so scale is the regime value itself
    assign scale_o = regime_k <<< posit_pkg::POSIT_ES;
    // hidden one above the single fraction bit
    assign frac_o  = {1'b1, frac_field[posit_pkg::POSIT_WIDTH-2]};

endmodule

// File: hdl/posit_mult.sv
module posit_mult (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // upstream side
    input  logic                                          rts_i,
    input  logic                                          sow_i,
    input  logic                                          eow_i,
    input  logic [posit_pkg::POSIT_WIDTH-1:0]             a_i,
    input  logic [posit_pkg::POSIT_WIDTH-1:0]             b_i,
    output logic                                          rtr_o,
    // downstream side
    input  logic                                          rtr_i,
    output logic                                          rts_o,
    output logic                                          sow_o,
    output logic                                          eow_o,
    output logic                                          sign_o,
    output logic                                          zero_o,
    output logic                                          nar_o,
    output logic signed [posit_pkg::PROD_SCALE_WIDTH-1:0] scale_o,
    output logic [posit_pkg::PROD_FRAC_WIDTH-1:0]         frac_o
);

    // decoded operands
    logic                                         sign_a, zero_a, nar_a;
    logic                                         sign_b, zero_b, nar_b;
    logic signed [posit_pkg::DEC_SCALE_WIDTH-1:0] scale_a, scale_b;
    logic [posit_pkg::DEC_FRAC_WIDTH-1:0]         frac_a, frac_b;

    // product fields before the register
    logic [posit_pkg::PROD_SCALE_WIDTH-1:0]       prod_scale;
    logic [posit_pkg::PROD_FRAC_WIDTH-1:0]        prod_frac;

    // stage control
    logic process_en;
    logic stage_en;
    logic stage_clr;
    logic staged;

    posit_decode u_dec_a (
        .posit_i (a_i),
        .sign_o  (sign_a),
        .zero_o  (zero_a),
        .nar_o   (nar_a),
        .scale_o (scale_a),
        .frac_o  (frac_a)
    );

    posit_decode u_dec_b (
        .posit_i (b_i),
        .sign_o  (sign_b),
        .zero_o  (zero_b),
        .nar_o   (nar_b),
        .scale_o (scale_b),
        .frac_o  (frac_b)
    );

    ////////////////////////////////////////////////////////////
    // product
    ////////////////////////////////////////////////////////////

    // sign extended scale sum
    assign prod_scale = {scale_a[posit_pkg::DEC_SCALE_WIDTH-1], scale_a} +
                        {scale_b[posit_pkg::DEC_SCALE_WIDTH-1], scale_b};
    // significand product, 1.x * 1.y
    assign prod_frac  = {2'b00, frac_a} * {2'b00, frac_b};

    ////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////

    // move when downstream takes the beat or the stage is empty
    assign process_en = rtr_i | ~staged;
    assign stage_en   = process_en & rts_i;
    assign stage_clr  = process_en & ~rts_i;
    // not registered, follows the stall in the same cycle
    assign rtr_o      = process_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            staged <= 1'b0;
            sow_o  <= 1'b0;
            eow_o  <= 1'b0;
        end else if (stage_en) begin
            staged <= 1'b1;
            sow_o  <= sow_i;
            eow_o  <= eow_i;
        end else if (stage_clr) begin
            staged <= 1'b0;
        end
    end

    // product payload
    always_ff @(posedge clk) begin
        if (stage_en) begin
            sign_o  <= sign_a ^ sign_b;
            zero_o  <= zero_a | zero_b;
            nar_o   <= nar_a | nar_b;
            scale_o <= prod_scale;
            frac_o  <= prod_frac;
        end
    end

    assign rts_o = staged;

endmodule

// File: hdl/quire_accum.sv
module quire_accum (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // product side
    input  logic                                          rts_i,
    input  logic                                          sow_i,
    input  logic                                          eow_i,
    input  logic                                          sign_i,
    input  logic                                          zero_i,
    input  logic                                          nar_i,
    input  logic signed [posit_pkg::PROD_SCALE_WIDTH-1:0] scale_i,
    input  logic [posit_pkg::PROD_FRAC_WIDTH-1:0]         frac_i,
    output logic                                          rtr_o,
    // result side
    input  logic                                          rtr_i,
    output logic                                          rts_o,
    output logic                                          sow_o,
    output logic                                          eow_o,
    output logic signed [quire_pkg::QUIRE_WIDTH-1:0]      data_o,
    output logic                                          sign_o,
    output logic                                          zero_o,
    output logic                                          nar_o
);

    // pipe control, index 0 is the input side
    logic       process_en;
    logic [1:0] stage_en;
    logic [1:0] stage_clr;
    logic [1:0] staged;
    logic [2:0] sow;
    logic [2:0] eow;

    // stage 1 alignment
    logic signed [posit_pkg::PROD_SCALE_WIDTH:0] shift_amt;
    logic [posit_pkg::PROD_SCALE_WIDTH:0]        shift_neg;
    logic [quire_pkg::SHIFTED_WIDTH-1:0]         frac_wide;
    logic [quire_pkg::SHIFTED_WIDTH-1:0]         aligned;
    logic [quire_pkg::SHIFTED_WIDTH-1:0]         shifted_r;
    logic                                        sign_r1;
    logic                                        zero_r1;
    logic                                        nar_r1;

    // stage 2 accumulation
    logic signed [quire_pkg::QUIRE_WIDTH-1:0]    addend;
    logic signed [quire_pkg::QUIRE_WIDTH-1:0]    base;
    logic signed [quire_pkg::QUIRE_WIDTH-1:0]    quire_next;
    logic signed [quire_pkg::QUIRE_WIDTH-1:0]    quire_r;
    logic                                        nar_hit;
    logic                                        nar_sticky;

    ////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////

    // whole pipe advances when the output is taken or empty
    assign process_en = rtr_i | ~staged[1];
    assign rtr_o      = process_en;
    assign sow[0]     = sow_i;
    assign eow[0]     = eow_i;

    assign stage_en[0]  = process_en & rts_i;
    assign stage_clr[0] = process_en & ~rts_i;
    assign stage_en[1]  = process_en & staged[0];
    assign stage_clr[1] = process_en & ~staged[0];

    ////////////////////////////////////////////////////////////
    // stage 1, align significand to the quire lsb
    ////////////////////////////////////////////////////////////

    assign shift_amt = {scale_i[posit_pkg::PROD_SCALE_WIDTH-1], scale_i} +
                       (posit_pkg::PROD_SCALE_WIDTH + 1)'(quire_pkg::SHIFT_BIAS);
    assign shift_neg = -shift_amt;
    assign frac_wide = {{(quire_pkg::SHIFTED_WIDTH - posit_pkg::PROD_FRAC_WIDTH){1'b0}}, frac_i};

    // right shifts only hit significands with trailing zeros, so exact
    always_comb begin
        if (!shift_amt[posit_pkg::PROD_SCALE_WIDTH]) begin
            aligned = frac_wide << shift_amt;
        end else begin
            aligned = frac_wide >> shift_neg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            staged[0] <= 1'b0;
            sow[1]    <= 1'b0;
            eow[1]    <= 1'b0;
        end else if (stage_en[0]) begin
            staged[0] <= 1'b1;
            sow[1]    <= sow[0];
            eow[1]    <= eow[0];
        end else if (stage_clr[0]) begin
            staged[0] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_en[0]) begin
            shifted_r <= aligned;
            sign_r1   <= sign_i;
            zero_r1   <= zero_i;
            nar_r1    <= nar_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2, quire update
    ////////////////////////////////////////////////////////////

    // magnitude is non-negative, zero extend
    assign addend = {{(quire_pkg::QUIRE_WIDTH - quire_pkg::SHIFTED_WIDTH){1'b0}}, shifted_r};
    // sticky nar, restarts with the window
    assign nar_hit = nar_r1 | (nar_sticky & ~sow[1]);

    always_comb begin
        base = sow[1] ? '0 : quire_r;
        if (nar_hit) begin
            // frozen while the window holds a nar
            quire_next = quire_r;
        end else if (zero_r1) begin
            quire_next = base;
        end else if (sign_r1) begin
            quire_next = base - addend;
        end else begin
            quire_next = base + addend;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            staged[1]  <= 1'b0;
            sow[2]     <= 1'b0;
            eow[2]     <= 1'b0;
            quire_r    <= '0;
            nar_sticky <= 1'b0;
        end else if (stage_en[1]) begin
            staged[1]  <= 1'b1;
            sow[2]     <= sow[1];
            eow[2]     <= eow[1];
            quire_r    <= quire_next;
            nar_sticky <= nar_hit;
        end else if (stage_clr[1]) begin
            staged[1] <= 1'b0;
        end
    end

    // result side
    assign rts_o  = staged[1];
    assign sow_o  = sow[2];
    assign eow_o  = eow[2];
    assign data_o = quire_r;
    assign sign_o = quire_r[quire_pkg::QUIRE_WIDTH-1];
    assign zero_o = ~|quire_r;
    assign nar_o  = nar_sticky;

endmodule

// File: hdl/posit_dot_top.sv
module posit_dot_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // operand stream
    input  logic                                     rts_i,
    output logic                                     rtr_o,
    input  logic [posit_pkg::POSIT_WIDTH-1:0]        a_i,
    input  logic [posit_pkg::POSIT_WIDTH-1:0]        b_i,
    input  logic                                     sow_i,
    input  logic                                     eow_i,
    // result stream
    output logic                                     rts_o,
    input  logic                                     rtr_i,
    output logic                                     sow_o,
    output logic                                     eow_o,
    output logic signed [quire_pkg::QUIRE_WIDTH-1:0] data_o,
    output logic                                     sign_o,
    output logic                                     zero_o,
    output logic                                     nar_o
);

    // product beat between multiplier and quire
    logic                                          p_rts;
    logic                                          p_rtr;
    logic                                          p_sow;
    logic                                          p_eow;
    logic                                          p_sign;
    logic                                          p_zero;
    logic                                          p_nar;
    logic signed [posit_pkg::PROD_SCALE_WIDTH-1:0] p_scale;
    logic [posit_pkg::PROD_FRAC_WIDTH-1:0]         p_frac;

    // decode and multiply, one cycle
    posit_mult u_mult (
        .clk     (clk),
        .rst_n   (rst_n),
        .rts_i   (rts_i),
        .sow_i   (sow_i),
        .eow_i   (eow_i),
        .a_i     (a_i),
        .b_i     (b_i),
        .rtr_o   (rtr_o),
        .rtr_i   (p_rtr),
        .rts_o   (p_rts),
        .sow_o   (p_sow),
        .eow_o   (p_eow),
        .sign_o  (p_sign),
        .zero_o  (p_zero),
        .nar_o   (p_nar),
        .scale_o (p_scale),
        .frac_o  (p_frac)
    );

    // align and accumulate, two cycles
    quire_accum u_quire (
        .clk     (clk),
        .rst_n   (rst_n),
        .rts_i   (p_rts),
        .sow_i   (p_sow),
        .eow_i   (p_eow),
        .sign_i  (p_sign),
        .zero_i  (p_zero),
        .nar_i   (p_nar),
        .scale_i (p_scale),
        .frac_i  (p_frac),
        .rtr_o   (p_rtr),
        .rtr_i   (rtr_i),
        .rts_o   (rts_o),
        .sow_o   (sow_o),
        .eow_o   (eow_o),
        .data_o  (data_o),
        .sign_o  (sign_o),
        .zero_o  (zero_o),
        .nar_o   (nar_o)
    );

endmodule

// File: verification/clk_gen.sv
module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 unit period
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // held low over five rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: verification/tb_posit_dot.sv
module tb_posit_dot;

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 2000;
    localparam int RESET_TIMEOUT  = 20;
    localparam int PIPE_LATENCY   = 3;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     rts_i;
    logic                                     rtr_o;
    logic [posit_pkg::POSIT_WIDTH-1:0]        a_i;
    logic [posit_pkg::POSIT_WIDTH-1:0]        b_i;
    logic                                     sow_i;
    logic                                     eow_i;
    logic                                     rts_o;
    logic                                     rtr_i;
    logic                                     sow_o;
    logic                                     eow_o;
    logic signed [quire_pkg::QUIRE_WIDTH-1:0] data_o;
    logic                                     sign_o;
    logic                                     zero_o;
    logic                                     nar_o;

    // expected beats in arrival order
    int exp_data[$];
    int exp_sow[$];
    int exp_eow[$];
    int exp_nar[$];
    int exp_cycle[$];
    // operand lists for a directed window
    int win_a[$];
    int win_b[$];

    // reference quire state
    int    model_q   = 0;
    bit    model_nar = 1'b0;
    int    checks    = 0;
    int    errors    = 0;
    int    cycle     = 0;
    bit    bp_mode   = 1'b0;
    bit    lat_check = 1'b1;
    int    seed      = 32'hc99e_8d11;
    int    bp_seed   = 32'hc99e_8d11 ^ 32'h5a5a_5a5a;
    string test_name = "reset";

    clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    posit_dot_top u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .rts_i  (rts_i),
        .rtr_o  (rtr_o),
        .a_i    (a_i),
        .b_i    (b_i),
        .sow_i  (sow_i),
        .eow_i  (eow_i),
        .rts_o  (rts_o),
        .rtr_i  (rtr_i),
        .sow_o  (sow_o),
        .eow_o  (eow_o),
        .data_o (data_o),
        .sign_o (sign_o),
        .zero_o (zero_o),
        .nar_o  (nar_o)
    );

    // rising edge count, read as the edge index before it updates
    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // posit<4,0> value in quarters
    function automatic int quarter_value(input logic [3:0] code);
        logic [3:0] mag;
        int         val;
        mag = code[3] ? (~code + 4'd1) : code;
        case (mag)
            4'd1: val = 1;
            4'd2: val = 2;
            4'd3: val = 3;
            4'd4: val = 4;
            4'd5: val = 6;
            4'd6: val = 8;
            4'd7: val = 16;
            default: val = 0;
        endcase
        return code[3] ? -val : val;
    endfunction

    // quire lsb is 1/16 so a product of quarters lands as is
    task automatic record_expected(input logic [3:0] a, input logic [3:0] b,
                                   input logic sow, input logic eow);
        int prod;
        bit nar_in;
        prod      = quarter_value(a) * quarter_value(b);
        nar_in    = (a == posit_pkg::NAR_PATTERN) || (b == posit_pkg::NAR_PATTERN);
        model_nar = nar_in || (model_nar && !sow);
        // frozen while nar holds
        if (!model_nar) begin
            model_q = sow ? prod : model_q + prod;
        end
        exp_data.push_back(model_q);
        exp_sow.push_back(int'(sow));
        exp_eow.push_back(int'(eow));
        exp_nar.push_back(int'(model_nar));
        exp_cycle.push_back(cycle);
    endtask

    ////////////////////////////////////////////////////////////
    // checking and run control
    ////////////////////////////////////////////////////////////

    task automatic check(input string label, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, label, expected, actual);
            errors++;
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("ERROR in %s, timed out because %s", test_name, what);
        errors++;
        end_run();
    endtask

    // one output beat against the head of the queue
    task automatic check_beat();
        int exp_val;
        int accepted_at;
        if (exp_data.size() == 0) begin
            $display("ERROR in %s, output beat arrived with nothing expected", test_name);
            errors++;
        end else begin
            exp_val     = exp_data.pop_front();
            accepted_at = exp_cycle.pop_front();
            check("data_o", exp_val, int'(data_o));
            check("sow_o", exp_sow.pop_front(), int'(sow_o));
            check("eow_o", exp_eow.pop_front(), int'(eow_o));
            check("nar_o", exp_nar.pop_front(), int'(nar_o));
            check("sign_o", (exp_val < 0) ? 1 : 0, int'(sign_o));
            check("zero_o", (exp_val == 0) ? 1 : 0, int'(zero_o));
            if (lat_check) begin
                check("latency", PIPE_LATENCY, cycle - accepted_at);
            end
        end
    endtask

    // output side, owns rtr_i
    initial begin
        rtr_i = 1'b1;
        forever begin
            @(negedge clk);
            if (bp_mode) begin
                rtr_i = (($random(bp_seed) & 3) != 0);
            end else begin
                rtr_i = 1'b1;
            end
            // beat is stable here and moves on the next rising edge
            if (rst_n && rts_o && rtr_i) begin
                check_beat();
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (!rst_n && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            abort_on_timeout("reset was never released");
        end else begin
            @(negedge clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_pair(input logic [3:0] a, input logic [3:0] b,
                             input logic sow, input logic eow);
        int waited;
        a_i    = a;
        b_i    = b;
        sow_i  = sow;
        eow_i  = eow;
        rts_i  = 1'b1;
        waited = 0;
        @(posedge clk);
        while (!rtr_o && waited < ACCEPT_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!rtr_o) begin
            abort_on_timeout("an input beat was never accepted");
        end else begin
            record_expected(a, b, sow, eow);
            @(negedge clk);
            rts_i = 1'b0;
        end
    endtask

    task automatic send_window();
        for (int i = 0; i < win_a.size(); i++) begin
            send_pair(4'(win_a[i]), 4'(win_b[i]), i == 0, i == win_a.size() - 1);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            abort_on_timeout("expected output beats never came out");
        end else begin
            @(negedge clk);
        end
    endtask

    // nar kept rare so most windows still accumulate
    function automatic logic [3:0] random_code();
        logic [3:0] code;
        code = 4'($random(seed));
        if (code == posit_pkg::NAR_PATTERN && (($random(seed) & 7) != 0)) begin
            code = 4'($random(seed) & 7);
        end
        return code;
    endfunction

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_single_products();
        test_name = "single_products";
        check("rts_o after reset", 0, int'(rts_o));
        check("sow_o after reset", 0, int'(sow_o));
        check("eow_o after reset", 0, int'(eow_o));
        check("rtr_o after reset", 1, int'(rtr_o));
        check("data_o after reset", 0, int'(data_o));
        // every positive pair as a one beat window
        for (int a = 1; a < 8; a++) begin
            for (int b = 1; b < 8; b++) begin
                send_pair(4'(a), 4'(b), 1'b1, 1'b1);
            end
        end
        wait_drain();
    endtask

    task automatic test_mixed_window();
        test_name = "mixed_window";
        // dot product ends negative, -263 quarters squared
        win_a = '{3, 14, 7, 1, 12, 5, 2, 15};
        win_b = '{5, 2, 9, 1, 6, 13, 7, 4};
        send_window();
        wait_drain();
    endtask

    task automatic test_zero_cancel();
        test_name = "zero_cancel";
        // zero product on the window start
        win_a = '{6, 2};
        win_b = '{0, 3};
        send_window();
        // +16 then -16 around zero operands
        win_a = '{4, 0, 12, 3};
        win_b = '{4, 5, 4, 0};
        send_window();
        wait_drain();
    endtask

    task automatic test_nar_window();
        test_name = "nar_window";
        win_a = '{2, 5, 8, 7, 3};
        win_b = '{3, 6, 4, 7, 3};
        send_window();
        win_a = '{6, 2};
        win_b = '{6, 2};
        send_window();
        // nar on the start beat itself
        win_a = '{9, 3};
        win_b = '{8, 3};
        send_window();
        win_a = '{1};
        win_b = '{2};
        send_window();
        wait_drain();
    endtask

    task automatic test_random_windows();
        int len;
        test_name = "random_windows";
        bp_mode   = 1'b1;
        lat_check = 1'b0;
        for (int w = 0; w < 24; w++) begin
            // second half runs with the output always ready
            if (w == 12) begin
                wait_drain();
                bp_mode   = 1'b0;
                lat_check = 1'b1;
            end
            len = 1 + int'($unsigned($random(seed)) % 64);
            for (int i = 0; i < len; i++) begin
                if (($random(seed) & 3) == 0) begin
                    idle_cycles(1 + int'($unsigned($random(seed)) % 3));
                end
                send_pair(random_code(), random_code(), i == 0, i == len - 1);
            end
        end
        wait_drain();
    endtask

    initial begin
        rts_i = 1'b0;
        a_i   = '0;
        b_i   = '0;
        sow_i = 1'b0;
        eow_i = 1'b0;
        wait_reset();
        test_single_products();
        test_mixed_window();
        test_zero_cancel();
        test_nar_window();
        test_random_windows();
        idle_cycles(4);
        end_run();
    end

endmodule

// File: list.f
hdl/posit_pkg.sv
hdl/quire_pkg.sv
hdl/posit_decode.sv
hdl/posit_mult.sv
hdl/quire_accum.sv
hdl/posit_dot_top.sv
verification/clk_gen.sv
verification/tb_posit_dot.sv

// File: run.sh
#!/usr/bin/env bash
# build with verilator and run, the pass line in the output decides the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_posit_dot \
    --Mdir obj_dir -o sim_posit_dot \
    && ./obj_dir/sim_posit_dot | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
